// ==== logic/rv_pkg.sv ====
// Shared widths, encodings, pipeline records and forwarding helpers, imported by every hart file
package rv_pkg;

    // ==============================
    // Widths and basic types
    // ==============================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;  // First fetch after reset

    // ==============================
    // Encodings
    // ==============================
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_XOR, ALU_OR, ALU_AND,
        ALU_PASS_B                                   // LUI immediate straight through
    } alu_op_e;

    // {funct3[2], funct3[0]} of the kept branches
    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GE} branch_e;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

    // ==============================
    // Pipeline records
    // ==============================
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;  // Operand B is the immediate
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    is_link;      // JAL, rd gets pc + 4
        logic    is_halt;      // EBREAK
        logic    valid;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     inst;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     inst;
        reg_addr_t rd;
        word_t     alu_result;  // Also the dmem address
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     inst;
        reg_addr_t rd;
        word_t     result;      // Final rd value
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        logic      halt;
        word_t     pc;
        word_t     inst;
        reg_addr_t rd;          // Zero when nothing is written
        word_t     rd_wdata;
    } retire_t;

    // ==============================
    // Forwarding helpers
    // ==============================
    function automatic logic writes_reg(ctrl_t c, reg_addr_t rd);
        return c.valid && c.reg_write && (rd != '0);
    endfunction

    // Non-load result of an EX/MEM entry
    function automatic word_t ex_result(ex_mem_t e);
        return e.ctrl.is_link ? e.pc + 32'd4 : e.alu_result;
    endfunction

    // Youngest producer wins
    function automatic fwd_sel_e fwd_sel(reg_addr_t rs, ex_mem_t em, mem_wb_t mw);
        if (writes_reg(em.ctrl, em.rd) && em.rd == rs) return FWD_MEM;
        if (writes_reg(mw.ctrl, mw.rd) && mw.rd == rs) return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic word_t fwd_data(fwd_sel_e sel, word_t rf, ex_mem_t em, mem_wb_t mw);
        case (sel)
            FWD_MEM: return ex_result(em);
            FWD_WB:  return mw.result;
            default: return rf;
        endcase
    endfunction

endpackage

// ==== logic/hazard_unit.sv ====
// Hazard unit, stalls IF/ID on load-use and unresolved branch operands
`timescale 1ns/100ps

module hazard_unit
    import rv_pkg::*;
(
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  logic      i_uses_rs1,
    input  logic      i_uses_rs2,
    input  logic      i_is_branch,
    input  logic      i_ifid_valid,
    input  id_ex_t    i_id_ex,
    input  ex_mem_t   i_ex_mem,
    output logic      o_stall,
    output logic      o_bubble
);

    logic id_ex_hit;
    logic ex_mem_hit;
    logic load_use;
    logic br_wait_ex;
    logic br_wait_mem;

    // Producer rd against a used, nonzero source of the IF/ID instruction
    function automatic logic src_hit(reg_addr_t rd);
        return (rd != '0) && ((i_uses_rs1 && rd == i_rs1) || (i_uses_rs2 && rd == i_rs2));
    endfunction

    assign id_ex_hit  = src_hit(i_id_ex.rd);
    assign ex_mem_hit = src_hit(i_ex_mem.rd);

    assign load_use    = i_id_ex.ctrl.valid && i_id_ex.ctrl.mem_read && id_ex_hit;
    assign br_wait_ex  = i_is_branch && writes_reg(i_id_ex.ctrl, i_id_ex.rd) && id_ex_hit;
    assign br_wait_mem = i_is_branch && i_ex_mem.ctrl.valid && i_ex_mem.ctrl.mem_read
                         && ex_mem_hit;                  // Load data not ready until WB

    assign o_stall  = load_use || br_wait_ex || br_wait_mem;
    assign o_bubble = o_stall && i_ifid_valid;

endmodule

// ==== logic/if_stage.sv ====
// Fetch stage, PC register and IF/ID register with stall hold and redirect flush
`timescale 1ns/100ps

module if_stage
    import rv_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_stall,        // Hazard hold
    input  logic  i_redirect,     // From ID
    input  word_t i_target,
    output word_t o_imem_addr,
    input  word_t i_imem_rdata,
    output word_t o_ifid_inst,
    output word_t o_ifid_pc,
    output logic  o_ifid_valid
);

    word_t r_pc;

    assign o_imem_addr = r_pc;    // Ideal imem, same-cycle data

    // PC: redirect beats stall, stall beats increment
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_pc <= RESET_PC;
        end else if (i_redirect) begin
            r_pc <= i_target;
        end else if (!i_stall) begin
            r_pc <= r_pc + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge i_clk) begin
        if (i_rst || i_redirect) begin
            o_ifid_valid <= 1'b0;  // Squash the wrong-path fetch
        end else if (!i_stall) begin
            o_ifid_valid <= 1'b1;
        end
        if (!i_stall) begin
            o_ifid_inst <= i_imem_rdata;
            o_ifid_pc   <= r_pc;
        end
    end

endmodule

// ==== logic/id_stage.sv ====
// Decode stage, register file, branch and JAL resolution, feeds the ID/EX register
`timescale 1ns/100ps

module id_stage
    import rv_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  word_t     i_ifid_inst,
    input  word_t     i_ifid_pc,
    input  logic      i_ifid_valid,
    input  logic      i_bubble,
    input  ex_mem_t   i_ex_mem,
    input  mem_wb_t   i_mem_wb,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    output logic      o_uses_rs1,
    output logic      o_uses_rs2,
    output logic      o_is_branch,
    output logic      o_redirect,
    output word_t     o_target,
    output id_ex_t    o_id_ex
);

    word_t      ir;
    opcode_e    opc;
    logic [2:0] funct3;
    ctrl_t      ctrl;
    word_t      imm;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      regs [1:31];  // x0 not stored
    word_t      rf_rs1;
    word_t      rf_rs2;
    word_t      br_a;
    word_t      br_b;
    branch_e    br;
    logic       taken;

    assign ir     = i_ifid_inst;
    assign opc    = opcode_e'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign o_rs1  = ir[19:15];
    assign o_rs2  = ir[24:20];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    // ==============================
    // Decoder
    // ==============================
    always_comb begin
        ctrl        = '0;
        imm         = imm_i;
        o_uses_rs1  = 1'b0;
        o_uses_rs2  = 1'b0;
        o_is_branch = 1'b0;
        case (opc)
            OPC_LUI: begin
                ctrl.alu_op      = ALU_PASS_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm              = {ir[31:12], 12'h000};
            end
            OPC_OP_IMM, OPC_OP: begin
                ctrl.alu_src_imm = (opc == OPC_OP_IMM);
                ctrl.reg_write   = 1'b1;
                o_uses_rs1       = 1'b1;
                o_uses_rs2       = (opc == OPC_OP);
                case (funct3)
                    3'b000:  ctrl.alu_op = (opc == OPC_OP && ir[30]) ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;   // Shifts, SLTU
                endcase
            end
            OPC_LOAD: begin                           // LW only
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = (funct3 == 3'b010);
                ctrl.reg_write   = (funct3 == 3'b010);
                o_uses_rs1       = 1'b1;
            end
            OPC_STORE: begin                          // SW only
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = (funct3 == 3'b010);
                imm              = imm_s;
                o_uses_rs1       = 1'b1;
                o_uses_rs2       = 1'b1;
            end
            OPC_BRANCH: begin
                imm         = imm_b;
                o_uses_rs1  = 1'b1;
                o_uses_rs2  = 1'b1;
                o_is_branch = 1'b1;
            end
            OPC_JAL: begin
                ctrl.is_link   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_j;
            end
            OPC_SYSTEM: ctrl.is_halt = (ir == 32'h0010_0073);  // EBREAK
            default: ;                                // Retires as a no-op
        endcase
        if (!i_ifid_valid) begin
            ctrl        = '0;
            o_uses_rs1  = 1'b0;
            o_uses_rs2  = 1'b0;
            o_is_branch = 1'b0;
        end
        ctrl.valid = i_ifid_valid;
    end

    // ==============================
    // Register file, WB write bypassed to reads
    // ==============================
    always_ff @(posedge i_clk) begin
        if (writes_reg(i_mem_wb.ctrl, i_mem_wb.rd)) begin
            regs[i_mem_wb.rd] <= i_mem_wb.result;
        end
    end

    assign rf_rs1 = (o_rs1 == '0) ? '0 : fwd_data(fwd_sel(o_rs1, '0, i_mem_wb), regs[o_rs1], '0,
                                                  i_mem_wb);
    assign rf_rs2 = (o_rs2 == '0) ? '0 : fwd_data(fwd_sel(o_rs2, '0, i_mem_wb), regs[o_rs2], '0,
                                                  i_mem_wb);

    // Branch operands, EX/MEM loads never get here thanks to the stall
    assign br_a = fwd_data(fwd_sel(o_rs1, i_ex_mem, i_mem_wb), rf_rs1, i_ex_mem, i_mem_wb);
    assign br_b = fwd_data(fwd_sel(o_rs2, i_ex_mem, i_mem_wb), rf_rs2, i_ex_mem, i_mem_wb);
    assign br   = branch_e'({funct3[2], funct3[0]});

    always_comb begin
        case (br)
            BR_EQ:   taken = (br_a == br_b);
            BR_NE:   taken = (br_a != br_b);
            BR_LT:   taken = ($signed(br_a) < $signed(br_b));
            default: taken = ($signed(br_a) >= $signed(br_b));
        endcase
    end

    // No redirect while waiting on operands; funct3[1] set means unsigned, not kept
    assign o_redirect = !i_bubble && (ctrl.is_link || (o_is_branch && !funct3[1] && taken));
    assign o_target   = i_ifid_pc + imm;

    // ID/EX register, bubble clears control only
    always_ff @(posedge i_clk) begin
        if (i_rst || i_bubble) begin
            o_id_ex.ctrl <= '0;
        end else begin
            o_id_ex.ctrl <= ctrl;
        end
        o_id_ex.pc       <= i_ifid_pc;
        o_id_ex.inst     <= ir;
        o_id_ex.rs1      <= o_rs1;
        o_id_ex.rs2      <= o_rs2;
        o_id_ex.rd       <= ir[11:7];
        o_id_ex.rs1_data <= rf_rs1;
        o_id_ex.rs2_data <= rf_rs2;
        o_id_ex.imm      <= imm;
    end

endmodule

// ==== logic/ex_stage.sv ====
// Execute stage, operand forwarding, ALU and the EX/MEM register
`timescale 1ns/100ps

module ex_stage
    import rv_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  id_ex_t  i_id_ex,
    input  mem_wb_t i_mem_wb,
    output ex_mem_t o_ex_mem
);

    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    word_t    op_a;
    word_t    rs2_val;   // Forwarded rs2, also the store data
    word_t    op_b;
    word_t    alu_out;
    logic     lt;

    // ==============================
    // Forwarding
    // ==============================
    // Own EX/MEM entry is the older neighbour, MEM/WB the one behind it
    assign sel_a   = fwd_sel(i_id_ex.rs1, o_ex_mem, i_mem_wb);
    assign sel_b   = fwd_sel(i_id_ex.rs2, o_ex_mem, i_mem_wb);
    assign op_a    = fwd_data(sel_a, i_id_ex.rs1_data, o_ex_mem, i_mem_wb);
    assign rs2_val = fwd_data(sel_b, i_id_ex.rs2_data, o_ex_mem, i_mem_wb);
    assign op_b    = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : rs2_val;

    // ==============================
    // ALU
    // ==============================
    assign lt = ($signed(op_a) < $signed(op_b));

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_out = op_a + op_b;    // Also load/store address
            ALU_SUB: alu_out = op_a - op_b;
            ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, lt};
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_AND: alu_out = op_a & op_b;
            default: alu_out = op_b;           // PASS_B for LUI
        endcase
    end

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex_mem.ctrl <= '0;
        end else begin
            o_ex_mem.ctrl <= i_id_ex.ctrl;
        end
        o_ex_mem.pc         <= i_id_ex.pc;
        o_ex_mem.inst       <= i_id_ex.inst;
        o_ex_mem.rd         <= i_id_ex.inst[11:7];
        o_ex_mem.alu_result <= alu_out;
        o_ex_mem.store_data <= rs2_val;
    end

endmodule

// ==== logic/mem_stage.sv ====
// Memory stage, dmem drive, result select, MEM/WB register and the retire record
`timescale 1ns/100ps

module mem_stage
    import rv_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  ex_mem_t i_ex_mem,
    output word_t   o_dmem_addr,
    output logic    o_dmem_ren,
    output logic    o_dmem_wen,
    output word_t   o_dmem_wdata,
    input  word_t   i_dmem_rdata,
    output mem_wb_t o_mem_wb,
    output retire_t o_retire
);

    word_t result;
    logic  wb_write;

    // Strobes only for a live entry
    assign o_dmem_addr  = i_ex_mem.alu_result;
    assign o_dmem_wdata = i_ex_mem.store_data;
    assign o_dmem_ren   = i_ex_mem.ctrl.valid && i_ex_mem.ctrl.mem_read;
    assign o_dmem_wen   = i_ex_mem.ctrl.valid && i_ex_mem.ctrl.mem_write;

    // Load data, link address or ALU value
    assign result = i_ex_mem.ctrl.mem_read ? i_dmem_rdata : ex_result(i_ex_mem);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_mem_wb.ctrl <= '0;
        end else begin
            o_mem_wb.ctrl <= i_ex_mem.ctrl;
        end
        o_mem_wb.pc     <= i_ex_mem.pc;
        o_mem_wb.inst   <= i_ex_mem.inst;
        o_mem_wb.rd     <= i_ex_mem.rd;
        o_mem_wb.result <= result;
    end

    // ==============================
    // Retire, same cycle as the register write
    // ==============================
    assign wb_write = writes_reg(o_mem_wb.ctrl, o_mem_wb.rd);

    always_comb begin
        o_retire.valid    = o_mem_wb.ctrl.valid;
        o_retire.halt     = o_mem_wb.ctrl.is_halt;
        o_retire.pc       = o_mem_wb.pc;
        o_retire.inst     = o_mem_wb.inst;
        o_retire.rd       = wb_write ? o_mem_wb.rd : '0;      // x0 and no-write report zero
        o_retire.rd_wdata = wb_write ? o_mem_wb.result : '0;
    end

endmodule

// ==== logic/hart.sv ====
// Top of the 5-stage RV32I hart, wires the stages and hazard unit to the imem and dmem ports
`timescale 1ns/100ps

module hart
    import rv_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,         // Sync, active high
    // Instruction memory, combinational read
    output word_t   o_imem_addr,
    input  word_t   i_imem_rdata,
    // Data memory, word access only
    output word_t   o_dmem_addr,
    output word_t   o_dmem_wdata,
    output logic    o_dmem_ren,
    output logic    o_dmem_wen,
    input  word_t   i_dmem_rdata,
    // Observation
    output retire_t o_retire
);

    // ==============================
    // Inter-stage traffic
    // ==============================
    word_t     ifid_inst;
    word_t     ifid_pc;
    logic      ifid_valid;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    logic      redirect;           // Taken branch or JAL in ID
    word_t     target;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      is_branch;
    logic      stall;              // Hold PC and IF/ID
    logic      bubble;             // Kill ID/EX entry

    if_stage u_if_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stall      (stall),
        .i_redirect   (redirect),
        .i_target     (target),
        .o_imem_addr  (o_imem_addr),
        .i_imem_rdata (i_imem_rdata),
        .o_ifid_inst  (ifid_inst),
        .o_ifid_pc    (ifid_pc),
        .o_ifid_valid (ifid_valid)
    );

    id_stage u_id_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_ifid_inst  (ifid_inst),
        .i_ifid_pc    (ifid_pc),
        .i_ifid_valid (ifid_valid),
        .i_bubble     (bubble),
        .i_ex_mem     (ex_mem),    // Branch operand forwarding
        .i_mem_wb     (mem_wb),    // Register file write
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_uses_rs1   (uses_rs1),
        .o_uses_rs2   (uses_rs2),
        .o_is_branch  (is_branch),
        .o_redirect   (redirect),
        .o_target     (target),
        .o_id_ex      (id_ex)
    );

    ex_stage u_ex_stage (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_id_ex  (id_ex),
        .i_mem_wb (mem_wb),
        .o_ex_mem (ex_mem)
    );

    mem_stage u_mem_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_ex_mem     (ex_mem),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_ren   (o_dmem_ren),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata),
        .o_mem_wb     (mem_wb),
        .o_retire     (o_retire)
    );

    hazard_unit u_hazard_unit (
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .i_uses_rs1   (uses_rs1),
        .i_uses_rs2   (uses_rs2),
        .i_is_branch  (is_branch),
        .i_ifid_valid (ifid_valid),
        .i_id_ex      (id_ex),
        .i_ex_mem     (ex_mem),
        .o_stall      (stall),
        .o_bubble     (bubble)
    );

endmodule

// ==== dv/hart_checker.sv ====
// Assertions on hart pipeline control, attached to the hart by bind
`timescale 1ns/100ps

module hart_checker
    import rv_pkg::*;
(
    input logic    i_clk,
    input logic    i_rst,
    input logic    i_stall,     // Hazard unit outputs
    input logic    i_bubble,
    input logic    i_dmem_ren,
    input logic    i_dmem_wen,
    input retire_t i_retire
);

    // A bubble only comes with a held front end
    a_bubble_stall: assert property (@(posedge i_clk) disable iff (i_rst) i_bubble |-> i_stall)
        else $error("Bubble without stall");

    a_reset_quiet: assert property (@(posedge i_clk)
        i_rst |=> (!i_retire.valid && !i_dmem_ren && !i_dmem_wen))
        else $error("Retire or dmem strobe after a reset cycle");

    a_dmem_mutex: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_dmem_ren && i_dmem_wen))
        else $error("Dmem read and write in one cycle");

endmodule

bind hart hart_checker u_hart_checker (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_stall    (stall),
    .i_bubble   (bubble),
    .i_dmem_ren (o_dmem_ren),
    .i_dmem_wen (o_dmem_wen),
    .i_retire   (o_retire)
);

// ==== dv/hart_tb.sv ====
// Testbench for the hart that runs a random program against a reference ISS and checks each access
`timescale 1ns/100ps

module hart_tb
    import rv_pkg::*;
();

    logic    clk = 1'b0;
    logic    rst;
    word_t   imem_addr;
    word_t   imem_rdata;
    word_t   dmem_addr;
    word_t   dmem_wdata;
    word_t   dmem_rdata;
    logic    dmem_ren;
    logic    dmem_wen;
    retire_t retire;

    word_t   imem [0:63];        // 64-word program
    word_t   dmem [0:255];       // DUT side data memory
    word_t   iss_mem [0:255];    // Model data memory
    word_t   iss_regs [0:31];
    retire_t exp_retire [$];
    word_t   exp_ld_addr [$];
    word_t   exp_st_addr [$];
    word_t   exp_st_data [$];
    integer  seed;
    int      cycles = 0;
    int      limit = 0;          // Set once the expected run is known

    always #4 clk = ~clk;        // 8 ns period

    hart dut (
        .i_clk        (clk),
        .i_rst        (rst),
        .o_imem_addr  (imem_addr),
        .i_imem_rdata (imem_rdata),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_ren   (dmem_ren),
        .o_dmem_wen   (dmem_wen),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    // ==============================
    // Memory models
    // ==============================
    // Past the program the fetch sees NOPs
    assign imem_rdata = (imem_addr[31:8] == '0) ? imem[imem_addr[7:2]] : 32'h0000_0013;
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (!rst && dmem_wen === 1'b1) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(1 + rand_below(7));   // x1 to x7
    endfunction

    // ==============================
    // Encoders and program build
    // ==============================
    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [2:0] alu_f3(int k);
        case (k)
            0:       return 3'b000;
            1:       return 3'b010;
            2:       return 3'b100;
            3:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    task automatic gen_program();
        int         kind;
        int         fwd;
        logic [6:0] f7;
        for (int i = 0; i < 7; i++) begin             // Every used register gets a value
            imem[i] = enc_i(12'(rand_below(4096)), 5'd0, 3'b000, reg_addr_t'(i + 1),
                            OPC_OP_IMM);
        end
        for (int i = 7; i < 63; i++) begin
            kind = rand_below(10);
            fwd  = 1 + rand_below(3);                  // Forward only so the run always ends
            if (i + fwd > 63) fwd = 63 - i;
            f7   = (rand_below(2) == 1) ? 7'h20 : 7'h00;
            case (kind)
                0, 1:    imem[i] = enc_r(f7, rand_reg(), rand_reg(), alu_f3(rand_below(5)),
                                         rand_reg());
                2, 3:    imem[i] = enc_i(12'(rand_below(4096)), rand_reg(),
                                         alu_f3(rand_below(5)), rand_reg(), OPC_OP_IMM);
                4:       imem[i] = {20'(rand_below(1 << 20)), rand_reg(), OPC_LUI};
                5, 6:    imem[i] = enc_i(12'(256 + 4 * rand_below(16)), 5'd0, 3'b010,
                                         rand_reg(), OPC_LOAD);       // 16-word window
                7:       imem[i] = enc_s(12'(256 + 4 * rand_below(16)), rand_reg(), 5'd0);
                8:       imem[i] = enc_b(13'(fwd * 4), rand_reg(), rand_reg(),
                                         {rand_below(2) == 1, 1'b0, rand_below(2) == 1});
                default: imem[i] = enc_j(21'(fwd * 4), rand_reg());
            endcase
        end
        imem[63] = 32'h0010_0073;                      // EBREAK
    endtask

    // ==============================
    // Reference ISS
    // ==============================
    function automatic retire_t iss_step(input word_t pc, output word_t next_pc,
                                         output logic ld, output word_t ld_addr,
                                         output logic st, output word_t st_addr,
                                         output word_t st_data);
        word_t     inst;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     op2;
        word_t     addr;
        word_t     res;
        logic      wr;
        logic      taken;
        retire_t   r;
        inst    = imem[pc[7:2]];
        a       = iss_regs[inst[19:15]];
        b       = iss_regs[inst[24:20]];
        imm     = {{20{inst[31]}}, inst[31:20]};
        op2     = (inst[6:0] == OPC_OP) ? b : imm;
        wr      = 1'b0;
        res     = '0;
        ld      = 1'b0;
        ld_addr = '0;
        st      = 1'b0;
        st_addr = '0;
        st_data = '0;
        next_pc = pc + 32'd4;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        r.inst  = inst;
        case (inst[6:0])
            OPC_LUI: begin
                wr  = 1'b1;
                res = {inst[31:12], 12'h000};
            end
            OPC_OP_IMM, OPC_OP: begin
                wr = 1'b1;
                case (inst[14:12])
                    3'b000:  res = (inst[5] && inst[30]) ? a - op2 : a + op2;
                    3'b010:  res = {31'd0, $signed(a) < $signed(op2)};
                    3'b100:  res = a ^ op2;
                    3'b110:  res = a | op2;
                    default: res = a & op2;
                endcase
            end
            OPC_LOAD: begin
                addr    = a + imm;
                wr      = 1'b1;
                res     = iss_mem[addr[9:2]];
                ld      = 1'b1;
                ld_addr = addr;
            end
            OPC_STORE: begin
                addr               = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                iss_mem[addr[9:2]] = b;
                st                 = 1'b1;
                st_addr            = addr;
                st_data            = b;
            end
            OPC_BRANCH: begin
                case (inst[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    default: taken = ($signed(a) >= $signed(b));
                endcase
                if (taken) begin
                    next_pc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                wr      = 1'b1;
                res     = pc + 32'd4;                  // Link value
                next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: r.halt = (inst == 32'h0010_0073);
        endcase
        if (wr && inst[11:7] != 5'd0) begin
            iss_regs[inst[11:7]] = res;
            r.rd                 = inst[11:7];
            r.rd_wdata           = res;
        end
        return r;
    endfunction

    // ==============================
    // Checks
    // ==============================
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_retire(string name, retire_t exp, retire_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Stimulus and expected queues
    initial begin
        word_t   pc;
        word_t   npc;
        word_t   la;
        word_t   sa;
        word_t   sd;
        logic    ld;
        logic    st;
        retire_t r;
        seed = 32'h0082_8edb;
        rst  = 1'b1;
        for (int i = 0; i < 256; i++) begin
            dmem[i]    = fill_word(word_t'(i * 4));
            iss_mem[i] = fill_word(word_t'(i * 4));
        end
        for (int i = 0; i < 32; i++) iss_regs[i] = '0;
        gen_program();
        pc = RESET_PC;
        do begin
            r = iss_step(pc, npc, ld, la, st, sa, sd);
            exp_retire.push_back(r);
            if (ld) begin
                exp_ld_addr.push_back(la);
            end
            if (st) begin
                exp_st_addr.push_back(sa);
                exp_st_data.push_back(sd);
            end
            pc = npc;
        end while (!r.halt);
        limit = 8 + 3 * exp_retire.size() + 20;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    end

    // Compare at mid-cycle when outputs are settled
    always @(negedge clk) begin
        retire_t exp;
        if (rst) begin
            if (retire.valid !== 1'b0 || dmem_ren !== 1'b0 || dmem_wen !== 1'b0) begin
                abort_run("Retire or dmem strobe active during reset");
            end
        end else begin
            if (dmem_ren === 1'b1) begin
                if (exp_ld_addr.size() == 0) begin
                    abort_run("Load seen on the dmem port that the ISS did not make");
                end else begin
                    check_word("load_addr", exp_ld_addr.pop_front(), dmem_addr);
                end
            end
            if (dmem_wen === 1'b1) begin
                if (exp_st_addr.size() == 0) begin
                    abort_run("Store seen on the dmem port that the ISS did not make");
                end else begin
                    check_word("store_addr", exp_st_addr.pop_front(), dmem_addr);
                    check_word("store_data", exp_st_data.pop_front(), dmem_wdata);
                end
            end
            if (retire.valid === 1'b1) begin
                if (exp_retire.size() == 0) begin
                    abort_run("Retire seen after the expected run ended");
                end else begin
                    exp = exp_retire.pop_front();
                    check_retire("retire", exp, retire);
                    if (exp.halt) begin
                        if (exp_st_addr.size() != 0 || exp_ld_addr.size() != 0) begin
                            abort_run("Halt retired with expected loads or stores still missing");
                        end else begin
                            $display("Done: no errors");
                            $finish;
                        end
                    end
                end
            end
        end
    end

    // Timeout
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            abort_run("Timeout, the halt did not retire in time");
        end
    end

endmodule

// ==== verilog.f ====
logic/rv_pkg.sv
logic/hazard_unit.sv
logic/if_stage.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/hart.sv
dv/hart_checker.sv
dv/hart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= hart_tb
CFLAGS    ?= -O2
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' verilog.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): verilog.f $(SRCS)
	$(VERILATOR) --binary --timing --assert -f verilog.f --top-module $(TOP) \
		-CFLAGS "$(CFLAGS)"

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
